/* logic/dc_defines.svh */
`ifndef DC_DEFINES_SVH
`define DC_DEFINES_SVH

// cache geometry
`define DC_WAYS    4
`define DC_SETS    16
`define DC_WORDS   4

// field widths
`define DC_TAG_W   8
`define DC_INDEX_W 4
`define DC_WORD_W  32

// index width must match the set count

`endif

/* logic/dc_pkg.sv */
`include "dc_defines.svh"

package dc_pkg;

  typedef logic [`DC_TAG_W-1:0]             tag_t;
  typedef logic [`DC_INDEX_W-1:0]           index_t;
  typedef logic [$clog2(`DC_WORDS)-1:0]     offset_t;

  // word address, tag then index then offset
  typedef logic [`DC_TAG_W+`DC_INDEX_W+$clog2(`DC_WORDS)-1:0] addr_t;

  typedef logic [`DC_WORD_W-1:0]            word_t;
  typedef logic [`DC_WORD_W/8-1:0]          ben_t;
  typedef logic [`DC_WORDS*`DC_WORD_W-1:0]  line_t;  // word 0 in low bits

  typedef logic [$clog2(`DC_WAYS)-1:0]      way_t;

  // 0 is most recent, WAYS-1 is the victim
  typedef logic [$clog2(`DC_WAYS)-1:0]      age_t;

  // one age per way, way 0 lowest
  typedef logic [`DC_WAYS*$clog2(`DC_WAYS)-1:0] set_ages_t;

  typedef logic [`DC_WAYS-1:0]              way_vec_t;

endpackage

/* logic/dc_req_if.sv */
`timescale 1ns/100ps

interface dc_req_if;
  import dc_pkg::*;

  index_t  rd_index;    // raw request index, captured by the rams
  logic    s1_read;
  logic    s1_write;
  logic    s1_insert;
  tag_t    s1_tag;
  index_t  s1_index;
  offset_t s1_offset;
  word_t   s1_wdata;
  ben_t    s1_ben;
  line_t   s1_fill;
  logic    init_busy;
  index_t  init_index;  // set being cleared

  modport pipe (output rd_index, s1_read, s1_write, s1_insert, s1_tag, s1_index,
                s1_offset, s1_wdata, s1_ben, s1_fill, init_busy, init_index);

  modport way (input rd_index, s1_read, s1_write, s1_insert, s1_tag, s1_index,
               s1_offset, s1_wdata, s1_ben, s1_fill, init_busy, init_index);

  modport lru (input rd_index, s1_read, s1_write, s1_insert, s1_index,
               s1_wdata, s1_ben, init_busy, init_index);

endinterface

/* logic/dc_ram.sv */
`timescale 1ns/100ps

module dc_ram #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic [WIDTH-1:0]         wr_data,
  output logic [WIDTH-1:0]         rd_data
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] rd_addr_q;

  // write first, a read after the write edge sees the new value
  assign rd_data = mem[rd_addr_q];

  always_ff @(posedge clk) begin
    if (rst) rd_addr_q <= '0;
    else rd_addr_q <= rd_addr;
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  a_wr_addr_known: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> !$isunknown(wr_addr));

endmodule

/* logic/dc_word_bank.sv */
`timescale 1ns/100ps
`include "dc_defines.svh"

module dc_word_bank #(
  parameter int BANK = 0
) (
  input  logic          clk,
  input  logic          rst,
  dc_req_if.way         req,
  input  logic          wr_en,
  input  dc_pkg::ben_t  wr_ben,
  output dc_pkg::word_t rd_word
);
  import dc_pkg::*;

  word_t  new_word;
  word_t  merged;
  word_t  wr_word;
  index_t wr_index;

  // read-modify-write merge against the stored word
  always_comb begin
    new_word = req.s1_insert ? req.s1_fill[BANK*`DC_WORD_W +: `DC_WORD_W] : req.s1_wdata;
    for (int i = 0; i < $bits(ben_t); i++) begin
      merged[i*8 +: 8] = wr_ben[i] ? new_word[i*8 +: 8] : rd_word[i*8 +: 8];
    end
  end

  assign wr_index = req.init_busy ? req.init_index : req.s1_index;
  assign wr_word  = req.init_busy ? '0 : merged;  // sweep clears the bank

  dc_ram #(.WIDTH(`DC_WORD_W), .DEPTH(`DC_SETS)) u_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (req.rd_index),
    .wr_en   (wr_en || req.init_busy),
    .wr_addr (wr_index),
    .wr_data (wr_word),
    .rd_data (rd_word)
  );

endmodule

/* logic/dc_way.sv */
`timescale 1ns/100ps
`include "dc_defines.svh"

module dc_way #(
  parameter int WAY = 0
) (
  input  logic          clk,
  input  logic          rst,
  dc_req_if.way         req,
  input  dc_pkg::way_t  victim,
  output logic          hit,
  output dc_pkg::word_t word,
  output dc_pkg::tag_t  tag,
  output logic          valid
);
  import dc_pkg::*;

  logic               fill_sel;     // this way takes the insert
  logic               tag_wr_en;
  index_t             tag_wr_index;
  logic [`DC_TAG_W:0] tag_wr_data;  // {valid, tag}
  logic [`DC_TAG_W:0] tag_rd_data;
  word_t              bank_word [`DC_WORDS];

  assign fill_sel = req.s1_insert && victim == way_t'(WAY);

  assign tag_wr_en    = fill_sel || req.init_busy;
  assign tag_wr_index = req.init_busy ? req.init_index : req.s1_index;
  assign tag_wr_data  = req.init_busy ? '0 : {1'b1, req.s1_tag};

  dc_ram #(.WIDTH(`DC_TAG_W + 1), .DEPTH(`DC_SETS)) u_tags (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (req.rd_index),
    .wr_en   (tag_wr_en),
    .wr_addr (tag_wr_index),
    .wr_data (tag_wr_data),
    .rd_data (tag_rd_data)
  );

  assign valid = tag_rd_data[`DC_TAG_W];
  assign tag   = tag_rd_data[`DC_TAG_W-1:0];

  // inserts never count as hits
  assign hit  = valid && tag == req.s1_tag && (req.s1_read || req.s1_write);
  assign word = bank_word[req.s1_offset];

  for (genvar b = 0; b < `DC_WORDS; b++) begin : g_bank
    logic bank_wr;
    ben_t bank_ben;

    assign bank_wr  = fill_sel ||
                      (hit && req.s1_write && req.s1_offset == offset_t'(b));
    assign bank_ben = fill_sel ? '1 : req.s1_ben;  // whole word on fill

    dc_word_bank #(.BANK(b)) u_bank (
      .clk     (clk),
      .rst     (rst),
      .req     (req),
      .wr_en   (bank_wr),
      .wr_ben  (bank_ben),
      .rd_word (bank_word[b])
    );
  end

endmodule

/* logic/dc_lru.sv */
`timescale 1ns/100ps
`include "dc_defines.svh"

module dc_lru (
  input  logic         clk,
  input  logic         rst,
  dc_req_if.lru        req,
  input  logic         hit_any,
  input  dc_pkg::way_t hit_way,
  output dc_pkg::way_t victim
);
  import dc_pkg::*;

  localparam int AW = $bits(age_t);

  set_ages_t           ages;       // ages of the staged set
  set_ages_t           new_ages;
  set_ages_t           init_ages;
  set_ages_t           wr_ages;
  logic                touch;
  way_t                touch_way;
  age_t                touch_age;
  logic                wr_en;
  index_t              wr_index;
  logic [`DC_WAYS-1:0] age_seen;

  dc_ram #(.WIDTH($bits(set_ages_t)), .DEPTH(`DC_SETS)) u_ages (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (req.rd_index),
    .wr_en   (wr_en),
    .wr_addr (wr_index),
    .wr_data (wr_ages),
    .rd_data (ages)
  );

  // oldest way is the victim
  always_comb begin
    victim = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (ages[w*AW +: AW] == age_t'(`DC_WAYS - 1)) victim = way_t'(w);
    end
  end

  assign touch     = hit_any || req.s1_insert;
  assign touch_way = req.s1_insert ? victim : hit_way;
  assign touch_age = ages[touch_way*AW +: AW];

  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      init_ages[w*AW +: AW] = age_t'(w);  // identity order
      if (way_t'(w) == touch_way) new_ages[w*AW +: AW] = '0;
      else if (ages[w*AW +: AW] < touch_age) new_ages[w*AW +: AW] = ages[w*AW +: AW] + 1'b1;
      else new_ages[w*AW +: AW] = ages[w*AW +: AW];
    end
  end

  assign wr_en    = touch || req.init_busy;
  assign wr_index = req.init_busy ? req.init_index : req.s1_index;
  assign wr_ages  = req.init_busy ? init_ages : new_ages;

  always_comb begin
    age_seen = '0;
    for (int w = 0; w < `DC_WAYS; w++) age_seen[ages[w*AW +: AW]] = 1'b1;
  end

  // sweep and every update keep each set a permutation
  a_ages_perm: assert property (@(posedge clk) disable iff (rst || req.init_busy)
    (req.s1_read || req.s1_write || req.s1_insert) |-> &age_seen);

endmodule

/* logic/dc_pipe.sv */
`timescale 1ns/100ps
`include "dc_defines.svh"

module dc_pipe (
  input  logic          clk,
  input  logic          rst,
  input  logic          read_en,
  input  logic          write_en,
  input  logic          insert,
  input  dc_pkg::addr_t addr,
  input  dc_pkg::word_t write_data,
  input  dc_pkg::ben_t  write_ben,
  input  dc_pkg::line_t fill_data,
  dc_req_if.pipe        req
);
  import dc_pkg::*;

  tag_t    addr_tag;
  index_t  addr_index;
  offset_t addr_offset;

  assign {addr_tag, addr_index, addr_offset} = addr;

  assign req.rd_index = addr_index;  // rams capture at the request edge

  // strobes, dropped while the sweep runs
  always_ff @(posedge clk) begin
    if (rst) begin
      req.s1_read   <= 1'b0;
      req.s1_write  <= 1'b0;
      req.s1_insert <= 1'b0;
    end else begin
      req.s1_read   <= read_en && !req.init_busy;
      req.s1_write  <= write_en && !req.init_busy;
      req.s1_insert <= insert && !req.init_busy;
    end
  end

  always_ff @(posedge clk) begin
    req.s1_tag    <= addr_tag;
    req.s1_index  <= addr_index;
    req.s1_offset <= addr_offset;
    req.s1_wdata  <= write_data;
    req.s1_ben    <= write_ben;
    req.s1_fill   <= fill_data;
  end

  // one set per cycle, busy drops after the last one
  always_ff @(posedge clk) begin
    if (rst) begin
      req.init_busy  <= 1'b1;
      req.init_index <= '0;
    end else if (req.init_busy) begin
      req.init_index <= req.init_index + 1'b1;
      if (req.init_index == index_t'(`DC_SETS - 1)) req.init_busy <= 1'b0;
    end
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    $onehot0({read_en, write_en, insert}));

endmodule

/* logic/dc_way_select.sv */
`timescale 1ns/100ps
`include "dc_defines.svh"

module dc_way_select (
  input  logic             clk,
  input  logic             rst,
  dc_req_if.lru            req,
  input  dc_pkg::way_vec_t hits,
  input  dc_pkg::word_t    words [`DC_WAYS],
  input  dc_pkg::tag_t     tags [`DC_WAYS],
  input  dc_pkg::way_vec_t valids,
  input  dc_pkg::way_t     victim,
  output logic             hit_any,
  output dc_pkg::way_t     hit_way,
  output logic             rsp_valid,
  output logic             rsp_hit,
  output dc_pkg::way_t     rsp_way,
  output dc_pkg::word_t    rsp_data,
  output logic             evict_valid,
  output dc_pkg::tag_t     evict_tag
);
  import dc_pkg::*;

  word_t hit_word;

  assign hit_any = |hits;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (hits[w]) hit_way = way_t'(w);
    end
  end

  // a write returns the word as it is stored
  always_comb begin
    hit_word = words[hit_way];
    for (int i = 0; i < $bits(ben_t); i++) begin
      if (req.s1_write && req.s1_ben[i]) hit_word[i*8 +: 8] = req.s1_wdata[i*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid   <= 1'b0;
      rsp_hit     <= 1'b0;
      evict_valid <= 1'b0;
    end else begin
      rsp_valid   <= req.s1_read || req.s1_write || req.s1_insert;
      rsp_hit     <= hit_any;
      evict_valid <= req.s1_insert && valids[victim];
    end
  end

  always_ff @(posedge clk) begin
    rsp_way   <= req.s1_insert ? victim : hit_way;
    rsp_data  <= hit_any ? hit_word : '0;  // zero on a miss
    evict_tag <= req.s1_insert ? tags[victim] : '0;
  end

  // at most one way may hold a given tag
  a_hits_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hits));

endmodule

/* logic/dc_top.sv */
`timescale 1ns/100ps
`include "dc_defines.svh"

module dc_top (
  input  logic          clk,
  input  logic          rst,
  input  logic          read_en,
  input  logic          write_en,
  input  logic          insert,
  input  dc_pkg::addr_t addr,
  input  dc_pkg::word_t write_data,
  input  dc_pkg::ben_t  write_ben,
  input  dc_pkg::line_t fill_data,
  output logic          init_busy,
  output logic          rsp_valid,
  output logic          rsp_hit,
  output dc_pkg::way_t  rsp_way,
  output dc_pkg::word_t rsp_data,
  output logic          evict_valid,
  output dc_pkg::tag_t  evict_tag
);
  import dc_pkg::*;

  way_vec_t hits;
  way_vec_t valids;
  word_t    words [`DC_WAYS];
  tag_t     tags [`DC_WAYS];
  logic     hit_any;
  way_t     hit_way;
  way_t     victim;

  dc_req_if req_if ();

  assign init_busy = req_if.init_busy;

  dc_pipe u_pipe (
    .clk        (clk),
    .rst        (rst),
    .read_en    (read_en),
    .write_en   (write_en),
    .insert     (insert),
    .addr       (addr),
    .write_data (write_data),
    .write_ben  (write_ben),
    .fill_data  (fill_data),
    .req        (req_if.pipe)
  );

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    dc_way #(.WAY(w)) u_way (
      .clk    (clk),
      .rst    (rst),
      .req    (req_if.way),
      .victim (victim),
      .hit    (hits[w]),
      .word   (words[w]),
      .tag    (tags[w]),
      .valid  (valids[w])
    );
  end

  dc_lru u_lru (
    .clk     (clk),
    .rst     (rst),
    .req     (req_if.lru),
    .hit_any (hit_any),
    .hit_way (hit_way),
    .victim  (victim)
  );

  dc_way_select u_sel (
    .clk         (clk),
    .rst         (rst),
    .req         (req_if.lru),
    .hits        (hits),
    .words       (words),
    .tags        (tags),
    .valids      (valids),
    .victim      (victim),
    .hit_any     (hit_any),
    .hit_way     (hit_way),
    .rsp_valid   (rsp_valid),
    .rsp_hit     (rsp_hit),
    .rsp_way     (rsp_way),
    .rsp_data    (rsp_data),
    .evict_valid (evict_valid),
    .evict_tag   (evict_tag)
  );

endmodule

/* tb/dc_checker.sv */
`timescale 1ns/100ps

module dc_checker (
  input  logic            clk,
  input  logic            rst,
  input  logic            rsp_valid,
  input  logic            rsp_hit,
  input  dc_pkg::way_t    rsp_way,
  input  dc_pkg::word_t   rsp_data,
  input  logic            evict_valid,
  input  dc_pkg::tag_t    evict_tag,
  input  logic            exp_push,
  input  logic [8*12-1:0] exp_name,
  input  logic [1:0]      exp_op,
  input  logic            exp_hit,
  input  dc_pkg::way_t    exp_way,
  input  dc_pkg::word_t   exp_data,
  input  logic            exp_evict_valid,
  input  dc_pkg::tag_t    exp_evict_tag,
  input  logic            report_now,
  output int              error_count,
  output int              pending
);
  import dc_pkg::*;

  localparam logic [1:0] OP_INSERT = 2'd2;
  localparam int RSP_TIMEOUT = 20;

  typedef struct packed {
    logic [8*12-1:0] name;
    logic [1:0]      op;
    logic            hit;
    way_t            way;
    word_t           data;
    logic            ev;
    tag_t            evtag;
  } exp_t;

  exp_t exp_q[$];  // issued, not yet answered
  int   errors = 0;
  int   check_count = 0;
  int   idle_cycles = 0;
  int   queued = 0;

  assign error_count = errors;
  assign pending     = queued;

  task automatic compare(input logic [8*12-1:0] name, input string field,
                         input logic [31:0] exp_v, input logic [31:0] act_v);
    check_count++;
    if (exp_v !== act_v) begin
      errors++;
      $display("[FAIL] %0s %0s expected %h actual %h", name, field, exp_v, act_v);
    end
  endtask

  task automatic check_row(input exp_t e);
    compare(e.name, "evict_valid", 32'(e.ev), 32'(evict_valid));
    if (e.op == OP_INSERT) begin
      compare(e.name, "way", 32'(e.way), 32'(rsp_way));
      if (e.ev) compare(e.name, "evict_tag", 32'(e.evtag), 32'(evict_tag));
    end else begin
      compare(e.name, "hit", 32'(e.hit), 32'(rsp_hit));
      if (e.hit) compare(e.name, "way", 32'(e.way), 32'(rsp_way));
      compare(e.name, "data", e.data, rsp_data);
    end
  endtask

  // outputs settle after the rising edge, look at them on the falling one
  always @(negedge clk) begin : watch
    exp_t e;
    if (!rst) begin
      if (rsp_valid) begin
        idle_cycles = 0;
        if (exp_q.size() == 0) begin
          errors++;
          $display("response seen with no request outstanding");
        end else begin
          e = exp_q.pop_front();
          check_row(e);
        end
      end else if (exp_q.size() != 0) begin
        idle_cycles++;
        if (idle_cycles > RSP_TIMEOUT) begin
          errors++;
          $display("no response to %0s within %0d cycles", exp_q[0].name, RSP_TIMEOUT);
          exp_q.delete();
          idle_cycles = 0;
        end
      end
      if (exp_push) exp_q.push_back({exp_name, exp_op, exp_hit, exp_way, exp_data,
                                     exp_evict_valid, exp_evict_tag});
    end
    queued = exp_q.size();
  end

  always @(posedge report_now) begin
    $display("checks %0d, errors %0d", check_count, errors);
  end

endmodule

/* tb/tb_dc_top.sv */
`timescale 1ns/100ps
`include "dc_defines.svh"

module tb_dc_top;
  import dc_pkg::*;

  localparam logic [1:0] OP_READ   = 2'd0;
  localparam logic [1:0] OP_WRITE  = 2'd1;
  localparam logic [1:0] OP_INSERT = 2'd2;
  localparam int INIT_TIMEOUT  = 40;
  localparam int DRAIN_TIMEOUT = 40;

  localparam tag_t   TAG_A = 8'h11;
  localparam tag_t   TAG_B = 8'h22;
  localparam tag_t   TAG_C = 8'h33;
  localparam tag_t   TAG_D = 8'h44;
  localparam tag_t   TAG_X = 8'h55;  // never inserted
  localparam tag_t   TAG_E = 8'h66;
  localparam tag_t   TAG_F = 8'h77;
  localparam index_t SET_MAIN  = 4'h5;
  localparam index_t SET_OTHER = 4'ha;

  typedef logic [8*12-1:0] name_t;

  typedef struct packed {
    name_t      name;
    logic [1:0] op;
    addr_t      addr;
    word_t      wdata;
    ben_t       ben;
    line_t      fill;
    logic       hit;
    way_t       way;
    word_t      data;
    logic       ev;
    tag_t       evtag;
  } row_t;

  logic  clk;
  logic  rst;
  logic  read_en;
  logic  write_en;
  logic  insert;
  addr_t addr;
  word_t write_data;
  ben_t  write_ben;
  line_t fill_data;
  logic  init_busy;
  logic  rsp_valid;
  logic  rsp_hit;
  way_t  rsp_way;
  word_t rsp_data;
  logic  evict_valid;
  tag_t  evict_tag;

  logic       exp_push;
  name_t      exp_name;
  logic [1:0] exp_op;
  logic       exp_hit;
  way_t       exp_way;
  word_t      exp_data;
  logic       exp_evict_valid;
  tag_t       exp_evict_tag;
  logic       report_now;
  int         error_count;
  int         pending;

  row_t rows[$];
  logic tb_ok;
  int   cycles;

  dc_top DUT (.*);

  dc_checker u_checker (.*);

  always #10 clk = ~clk;

  // tag, index and offset packed into the word with a marker byte on top
  function automatic word_t fill_word(input tag_t tag, input index_t idx, input offset_t off);
    return {8'hc0, tag, 4'h0, idx, 6'h0, off};
  endfunction

  function automatic line_t fill_line(input tag_t tag, input index_t idx);
    line_t l;
    for (int o = 0; o < `DC_WORDS; o++) begin
      l[o*`DC_WORD_W +: `DC_WORD_W] = fill_word(tag, idx, offset_t'(o));
    end
    return l;
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input ben_t ben);
    word_t r;
    for (int i = 0; i < 4; i++) r[i*8 +: 8] = ben[i] ? new_w[i*8 +: 8] : old_w[i*8 +: 8];
    return r;
  endfunction

  task automatic add_read(input name_t name, input tag_t tag, input index_t idx,
                          input offset_t off, input logic hit, input way_t way, input word_t data);
    row_t r;
    r = '0;
    r.name = name;
    r.op   = OP_READ;
    r.addr = {tag, idx, off};
    r.hit  = hit;
    r.way  = way;
    r.data = data;
    rows.push_back(r);
  endtask

  task automatic add_write(input name_t name, input tag_t tag, input index_t idx,
                           input offset_t off, input word_t wdata, input ben_t ben,
                           input logic hit, input way_t way, input word_t data);
    row_t r;
    r = '0;
    r.name  = name;
    r.op    = OP_WRITE;
    r.addr  = {tag, idx, off};
    r.wdata = wdata;
    r.ben   = ben;
    r.hit   = hit;
    r.way   = way;
    r.data  = data;
    rows.push_back(r);
  endtask

  task automatic add_insert(input name_t name, input tag_t tag, input index_t idx,
                            input way_t way, input logic ev, input tag_t evtag);
    row_t r;
    r = '0;
    r.name  = name;
    r.op    = OP_INSERT;
    r.addr  = {tag, idx, 2'd0};
    r.fill  = fill_line(tag, idx);
    r.way   = way;
    r.ev    = ev;
    r.evtag = evtag;
    rows.push_back(r);
  endtask

  task automatic build_table();
    word_t b1_merged;
    b1_merged = merge_bytes(fill_word(TAG_B, SET_MAIN, 2'd1), 32'h1234_5678, 4'b0101);
    add_read("rd_cold", TAG_A, SET_MAIN, 2'd0, 1'b0, 2'd0, '0);
    add_read("rd_cold_f", 8'h3c, 4'hf, 2'd3, 1'b0, 2'd0, '0);
    // identity ages so ways fill from 3 down
    add_insert("ins_a", TAG_A, SET_MAIN, 2'd3, 1'b0, '0);
    add_insert("ins_b", TAG_B, SET_MAIN, 2'd2, 1'b0, '0);
    add_insert("ins_c", TAG_C, SET_MAIN, 2'd1, 1'b0, '0);
    add_insert("ins_d", TAG_D, SET_MAIN, 2'd0, 1'b0, '0);
    add_read("rd_a0", TAG_A, SET_MAIN, 2'd0, 1'b1, 2'd3, fill_word(TAG_A, SET_MAIN, 2'd0));
    add_read("rd_b1", TAG_B, SET_MAIN, 2'd1, 1'b1, 2'd2, fill_word(TAG_B, SET_MAIN, 2'd1));
    add_read("rd_c2", TAG_C, SET_MAIN, 2'd2, 1'b1, 2'd1, fill_word(TAG_C, SET_MAIN, 2'd2));
    add_read("rd_d3", TAG_D, SET_MAIN, 2'd3, 1'b1, 2'd0, fill_word(TAG_D, SET_MAIN, 2'd3));
    add_write("wr_b1", TAG_B, SET_MAIN, 2'd1, 32'h1234_5678, 4'b0101, 1'b1, 2'd2, b1_merged);
    add_read("rd_b1_m", TAG_B, SET_MAIN, 2'd1, 1'b1, 2'd2, b1_merged);
    add_write("wr_miss", TAG_X, SET_MAIN, 2'd0, 32'hdead_beef, 4'hf, 1'b0, 2'd0, '0);
    add_read("rd_c0", TAG_C, SET_MAIN, 2'd0, 1'b1, 2'd1, fill_word(TAG_C, SET_MAIN, 2'd0));
    add_read("rd_d0", TAG_D, SET_MAIN, 2'd0, 1'b1, 2'd0, fill_word(TAG_D, SET_MAIN, 2'd0));
    // ages now 0,1,2,3 for ways 0..3 and way 3 holds A
    add_insert("ins_e", TAG_E, SET_MAIN, 2'd3, 1'b1, TAG_A);
    add_read("rd_a_gone", TAG_A, SET_MAIN, 2'd0, 1'b0, 2'd0, '0);
    add_read("rd_e1", TAG_E, SET_MAIN, 2'd1, 1'b1, 2'd3, fill_word(TAG_E, SET_MAIN, 2'd1));
    // touching B moves the victim on to C
    add_read("rd_b3", TAG_B, SET_MAIN, 2'd3, 1'b1, 2'd2, fill_word(TAG_B, SET_MAIN, 2'd3));
    add_insert("ins_f", TAG_F, SET_MAIN, 2'd1, 1'b1, TAG_C);
    add_read("rd_c_gone", TAG_C, SET_MAIN, 2'd0, 1'b0, 2'd0, '0);
    add_write("wr_e2", TAG_E, SET_MAIN, 2'd2, 32'hcafe_f00d, 4'hf, 1'b1, 2'd3, 32'hcafe_f00d);
    add_read("rd_e2", TAG_E, SET_MAIN, 2'd2, 1'b1, 2'd3, 32'hcafe_f00d);
    add_insert("ins_a_s10", TAG_A, SET_OTHER, 2'd3, 1'b0, '0);
    add_read("rd_a_s10", TAG_A, SET_OTHER, 2'd1, 1'b1, 2'd3, fill_word(TAG_A, SET_OTHER, 2'd1));
  endtask

  task automatic idle_inputs();
    read_en    = 1'b0;
    write_en   = 1'b0;
    insert     = 1'b0;
    addr       = '0;
    write_data = '0;
    write_ben  = '0;
    fill_data  = '0;
  endtask

  // request and its expected response go out together
  task automatic apply_row(input row_t r);
    read_en         = (r.op == OP_READ);
    write_en        = (r.op == OP_WRITE);
    insert          = (r.op == OP_INSERT);
    addr            = r.addr;
    write_data      = r.wdata;
    write_ben       = r.ben;
    fill_data       = r.fill;
    exp_push        = 1'b1;
    exp_name        = r.name;
    exp_op          = r.op;
    exp_hit         = r.hit;
    exp_way         = r.way;
    exp_data        = r.data;
    exp_evict_valid = r.ev;
    exp_evict_tag   = r.evtag;
  endtask

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    idle_inputs();
    exp_push        = 1'b0;
    exp_name        = '0;
    exp_op          = OP_READ;
    exp_hit         = 1'b0;
    exp_way         = '0;
    exp_data        = '0;
    exp_evict_valid = 1'b0;
    exp_evict_tag   = '0;
    report_now      = 1'b0;
    tb_ok           = 1'b1;
    build_table();
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;
    cycles = 0;
    while (init_busy && cycles < INIT_TIMEOUT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (init_busy) begin
      tb_ok = 1'b0;
      $display("init sweep still busy after %0d cycles", INIT_TIMEOUT);
    end else begin
      foreach (rows[i]) begin
        apply_row(rows[i]);
        @(posedge clk);
        #2;
      end
      idle_inputs();
      exp_push = 1'b0;
      cycles = 0;
      while (pending != 0 && cycles < DRAIN_TIMEOUT) begin
        @(posedge clk);
        #2;
        cycles++;
      end
      if (pending != 0) begin
        tb_ok = 1'b0;
        $display("%0d responses still outstanding at the end of the run", pending);
      end
    end
    report_now = 1'b1;
    #1;
    if (tb_ok && error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+logic
logic/dc_pkg.sv
logic/dc_req_if.sv
logic/dc_ram.sv
logic/dc_word_bank.sv
logic/dc_way.sv
logic/dc_lru.sv
logic/dc_pipe.sv
logic/dc_way_select.sv
logic/dc_top.sv
tb/dc_checker.sv
tb/tb_dc_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_dc_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
